/* src/icache_pkg.sv */
// ########################################
// Instruction cache shared definitions
// Geometry and vector types for the fetch-stage I$
// ########################################

package icache_pkg;

    // ########################################
    // Geometry

    // Instructions handed to the decoder per request
    localparam int unsigned FetchWidth   = 2;
    localparam int unsigned PcWidth      = 8;
    localparam int unsigned EncInstWidth = 4;

    // Word select within a line, lowest PC bits
    localparam int unsigned LineIdxBits = 2;
    localparam int unsigned LineWords   = 1 << LineIdxBits;

    // Line select, directly above the offset
    localparam int unsigned IndexBits = 3;
    localparam int unsigned NumLines  = 1 << IndexBits;

    // Remaining upper PC bits form the tag
    localparam int unsigned TagBits       = PcWidth - IndexBits - LineIdxBits;
    localparam int unsigned LineAddrWidth = PcWidth - LineIdxBits;

    // Warp sideband
    localparam int unsigned NumWarps    = 8;
    localparam int unsigned WarpIdWidth = $clog2(NumWarps);
    localparam int unsigned WarpWidth   = 32;

    // ########################################
    // Vector types

    typedef logic [PcWidth-1:0]       pc_t;
    // PC without the offset, also the memory address
    typedef logic [LineAddrWidth-1:0] line_addr_t;
    typedef logic [TagBits-1:0]       tag_t;
    typedef logic [IndexBits-1:0]     index_t;
    typedef logic [LineIdxBits-1:0]   offset_t;
    typedef logic [EncInstWidth-1:0]  enc_inst_t;
    // Word 0 sits in the lowest bits
    typedef logic [LineWords*EncInstWidth-1:0]  line_t;
    typedef logic [FetchWidth-1:0]              fetch_mask_t;
    // Slot 0 sits in the lowest bits
    typedef logic [FetchWidth*EncInstWidth-1:0] inst_vec_t;
    typedef logic [WarpWidth-1:0]               act_mask_t;
    typedef logic [WarpIdWidth-1:0]             warp_id_t;

endpackage : icache_pkg

/* src/icache_line_if.sv */
// ########################################
// Controller to line store link
// Lookup, refill and flush of the line arrays
// ########################################

`timescale 1ns/1ps

interface icache_line_if;

    // Strobes from the controller, one cycle each
    logic lookup;
    logic refill;
    logic flush;

    // Line select and tag of the current request
    icache_pkg::index_t index;
    icache_pkg::tag_t   tag;

    // Line returned by memory
    icache_pkg::line_t wdata;

    // Lookup result, valid the cycle after lookup
    logic              hit;
    icache_pkg::line_t rdata;

    modport ctrl (
        output lookup, refill, flush, index, tag, wdata,
        input  hit, rdata
    );

    modport store (
        input  lookup, refill, flush, index, tag, wdata,
        output hit, rdata
    );

endinterface : icache_line_if

/* src/icache_window_if.sv */
// ########################################
// Controller to window extractor link
// ########################################

`timescale 1ns/1ps

interface icache_window_if;

    // Source line and request fields
    logic                    present;
    icache_pkg::line_t       line;
    icache_pkg::offset_t     offset;
    icache_pkg::fetch_mask_t fetch_mask;

    // Decoder-facing window
    icache_pkg::fetch_mask_t slot_valid;
    icache_pkg::inst_vec_t   insts;

    modport ctrl    (output present, line, offset, fetch_mask, input slot_valid, insts);
    modport extract (input present, line, offset, fetch_mask, output slot_valid, insts);

endinterface : icache_window_if

/* src/icache_line_store.sv */
// ########################################
// Instruction cache line store
// Tag/data arrays, valid bits, registered lookup
// ########################################

`timescale 1ns/1ps

module icache_line_store (
    input logic clk_i,
    input logic rst_ni,

    icache_line_if.store line_if
);

    // ########################################
    // Storage

    // Plain register arrays, one entry per line
    icache_pkg::tag_t  tag_mem  [icache_pkg::NumLines];
    icache_pkg::line_t data_mem [icache_pkg::NumLines];

    // One valid bit per line
    logic [icache_pkg::NumLines-1:0] valid_q;

    // Lookup result
    logic              hit_q;
    icache_pkg::line_t rdata_q;

    // ########################################
    // Control state

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            hit_q   <= 1'b0;
        end else begin
            // Flush drops every line at once
            if (line_if.flush) begin
                valid_q <= '0;
            end else if (line_if.refill) begin
                valid_q[line_if.index] <= 1'b1;
            end

            // Hit needs valid line and matching tag
            if (line_if.lookup) begin
                hit_q <= valid_q[line_if.index]
                         && (tag_mem[line_if.index] == line_if.tag);
            end
        end
    end

    // ########################################
    // Arrays and read register

    always_ff @(posedge clk_i) begin
        if (line_if.refill) begin
            tag_mem[line_if.index]  <= line_if.tag;
            data_mem[line_if.index] <= line_if.wdata;
        end
        // One-cycle read, held until the next lookup
        if (line_if.lookup) begin
            rdata_q <= data_mem[line_if.index];
        end
    end

    assign line_if.hit   = hit_q;
    assign line_if.rdata = rdata_q;

endmodule : icache_line_store

/* src/icache_ctrl.sv */
// ########################################
// Instruction cache request controller
// Request FSM, refill register and memory request
// ########################################

`timescale 1ns/1ps

module icache_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // Fetcher request
    input  logic                    fe_valid_i,
    input  icache_pkg::fetch_mask_t fe_fetch_mask_i,
    input  icache_pkg::pc_t         fe_pc_i,
    input  icache_pkg::act_mask_t   fe_act_mask_i,
    input  icache_pkg::warp_id_t    fe_warp_id_i,
    output logic                    ic_ready_o,
    // Decoder sideband
    input  logic                    dec_ready_i,
    output icache_pkg::fetch_mask_t ic_fetch_mask_o,
    output icache_pkg::pc_t         ic_pc_o,
    output icache_pkg::act_mask_t   ic_act_mask_o,
    output icache_pkg::warp_id_t    ic_warp_id_o,
    // Memory request and response
    input  logic                    mem_ready_i,
    input  logic                    mem_valid_i,
    input  icache_pkg::line_t       mem_data_i,
    output logic                    mem_req_o,
    output icache_pkg::line_addr_t  mem_addr_o,

    icache_line_if.ctrl   line_if,
    icache_window_if.ctrl win_if
);

    typedef enum logic [1:0] {
        st_idle,       // waiting for a fetch request
        st_handle_req, // lookup result available
        st_wait_mem,   // line request sent
        st_wait_dec    // refill line held for the decoder
    } state_e;

    state_e state_q, state_d;
    logic   flush_q;

    // Active request
    icache_pkg::pc_t         pc_q;
    icache_pkg::fetch_mask_t fetch_mask_q;
    icache_pkg::act_mask_t   act_mask_q;
    icache_pkg::warp_id_t    warp_id_q;

    // Line returned by memory
    icache_pkg::line_t refill_q;

    logic present, done, free, accept, apply_flush, refill;

    // ########################################
    // Handshakes

    // Something for the decoder this cycle
    assign present = ((state_q == st_handle_req) && line_if.hit) || (state_q == st_wait_dec);
    // Contiguous masks always start at slot 0
    assign done    = win_if.slot_valid[0] && dec_ready_i;
    // Idle, or finishing the current delivery
    assign free    = (state_q == st_idle) || done;

    // Pending flush goes first and blocks new requests
    assign apply_flush = free && flush_q;
    assign ic_ready_o  = free && !flush_q;
    assign accept      = fe_valid_i && ic_ready_o;
    assign refill      = (state_q == st_wait_mem) && mem_valid_i;

    // Single outstanding line request, held until taken
    assign mem_req_o  = (state_q == st_handle_req) && !line_if.hit;
    assign mem_addr_o = pc_q[icache_pkg::PcWidth-1:icache_pkg::LineIdxBits];

    // ########################################
    // Line store and window

    // New request looks up with its own PC, refill uses the stored one
    assign line_if.lookup = accept;
    assign line_if.refill = refill;
    assign line_if.flush  = apply_flush;
    assign line_if.index  = accept
        ? fe_pc_i[icache_pkg::LineIdxBits +: icache_pkg::IndexBits]
        : pc_q[icache_pkg::LineIdxBits +: icache_pkg::IndexBits];
    assign line_if.tag    = accept
        ? fe_pc_i[icache_pkg::PcWidth-1 -: icache_pkg::TagBits]
        : pc_q[icache_pkg::PcWidth-1 -: icache_pkg::TagBits];
    assign line_if.wdata  = mem_data_i;

    assign win_if.present    = present;
    // Hit reads the store, refill path reads the held line
    assign win_if.line       = (state_q == st_wait_dec) ? refill_q : line_if.rdata;
    assign win_if.offset     = pc_q[icache_pkg::LineIdxBits-1:0];
    assign win_if.fetch_mask = fetch_mask_q;

    // Sideband zero while nothing is delivered
    assign ic_fetch_mask_o = present ? fetch_mask_q : '0;
    assign ic_pc_o         = present ? pc_q : '0;
    assign ic_act_mask_o   = present ? act_mask_q : '0;
    assign ic_warp_id_o    = present ? warp_id_q : '0;

    // ########################################
    // Next state

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            st_idle:       if (accept) state_d = st_handle_req;
            st_handle_req: begin
                if (done) begin
                    state_d = accept ? st_handle_req : st_idle;
                end else if (mem_req_o && mem_ready_i) begin
                    state_d = st_wait_mem;
                end
            end
            st_wait_mem:   if (mem_valid_i) state_d = st_wait_dec;
            st_wait_dec:   if (done) state_d = accept ? st_handle_req : st_idle;
            default:       state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= st_idle;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // A strobe in the apply cycle stays pending
            flush_q <= flush_i || (flush_q && !apply_flush);
        end
    end

    // Request and refill payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pc_q         <= fe_pc_i;
            fetch_mask_q <= fe_fetch_mask_i;
            act_mask_q   <= fe_act_mask_i;
            warp_id_q    <= fe_warp_id_i;
        end
        if (refill) begin
            refill_q <= mem_data_i;
        end
    end

endmodule : icache_ctrl

/* src/icache_window_extract.sv */
// ########################################
// Fetch window extractor
// Slices decoder slots out of a cache line
// ########################################

`timescale 1ns/1ps

module icache_window_extract (
    icache_window_if.extract win_if
);

    // ########################################
    // Slot selection

    // Slot k takes word offset+k, never past the line end
    always_comb begin
        int                  pos;
        icache_pkg::offset_t word;

        // Invalid slots carry zero
        win_if.slot_valid = '0;
        win_if.insts      = '0;
        pos               = 0;
        word              = '0;

        for (int k = 0; k < int'(icache_pkg::FetchWidth); k++) begin
            // Untruncated position decides the line end
            pos  = int'(win_if.offset) + k;
            word = icache_pkg::offset_t'(pos);

            if (win_if.present && win_if.fetch_mask[k]
                && (pos < int'(icache_pkg::LineWords))) begin
                win_if.slot_valid[k] = 1'b1;
                win_if.insts[k*icache_pkg::EncInstWidth +: icache_pkg::EncInstWidth] =
                    win_if.line[word*icache_pkg::EncInstWidth +: icache_pkg::EncInstWidth];
            end
        end
    end

endmodule : icache_window_extract

/* src/icache_top.sv */
// ########################################
// Direct-mapped instruction cache top
// Fetcher, decoder and memory ports
// ########################################

`timescale 1ns/1ps

module icache_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    // Memory request and response
    input  logic                    mem_ready_i,
    output logic                    mem_req_o,
    output icache_pkg::line_addr_t  mem_addr_o,
    input  logic                    mem_valid_i,
    input  icache_pkg::line_t       mem_data_i,
    // Fetcher
    output logic                    ic_ready_o,
    input  logic                    fe_valid_i,
    input  icache_pkg::fetch_mask_t fe_fetch_mask_i,
    input  icache_pkg::pc_t         fe_pc_i,
    input  icache_pkg::act_mask_t   fe_act_mask_i,
    input  icache_pkg::warp_id_t    fe_warp_id_i,
    // Decoder
    input  logic                    dec_ready_i,
    output icache_pkg::fetch_mask_t ic_valid_o,
    output icache_pkg::inst_vec_t   ic_inst_o,
    output icache_pkg::fetch_mask_t ic_fetch_mask_o,
    output icache_pkg::pc_t         ic_pc_o,
    output icache_pkg::act_mask_t   ic_act_mask_o,
    output icache_pkg::warp_id_t    ic_warp_id_o
);

    icache_line_if   line_if ();
    icache_window_if win_if ();

    // Request FSM
    icache_ctrl i_ctrl (
        .clk_i, .rst_ni, .flush_i,
        .fe_valid_i, .fe_fetch_mask_i, .fe_pc_i, .fe_act_mask_i, .fe_warp_id_i,
        .ic_ready_o, .dec_ready_i,
        .ic_fetch_mask_o, .ic_pc_o, .ic_act_mask_o, .ic_warp_id_o,
        .mem_ready_i, .mem_valid_i, .mem_data_i, .mem_req_o, .mem_addr_o,
        .line_if (line_if),
        .win_if  (win_if)
    );

    // Tags, valids and line data
    icache_line_store i_line_store (
        .clk_i, .rst_ni,
        .line_if (line_if)
    );

    // Decoder window
    icache_window_extract i_window_extract (
        .win_if (win_if)
    );

    assign ic_valid_o = win_if.slot_valid;
    assign ic_inst_o  = win_if.insts;

endmodule : icache_top

/* verif/icache_tb.sv */
// ########################################
// Instruction cache testbench
// Memory model, random stalls, window checks
// ########################################

`timescale 1ns/1ps

module icache_tb;

    logic                    clk_i, rst_ni, flush_i;
    logic                    mem_ready_i, mem_req_o, mem_valid_i;
    icache_pkg::line_addr_t  mem_addr_o;
    icache_pkg::line_t       mem_data_i;
    logic                    ic_ready_o, fe_valid_i, dec_ready_i;
    icache_pkg::fetch_mask_t fe_fetch_mask_i, ic_valid_o, ic_fetch_mask_o;
    icache_pkg::pc_t         fe_pc_i, ic_pc_o;
    icache_pkg::act_mask_t   fe_act_mask_i, ic_act_mask_o;
    icache_pkg::warp_id_t    fe_warp_id_i, ic_warp_id_o;
    icache_pkg::inst_vec_t   ic_inst_o;

    // Accepted requests in order, popped on delivery
    icache_pkg::pc_t         exp_pc   [$];
    icache_pkg::fetch_mask_t exp_mask [$];
    icache_pkg::act_mask_t   exp_act  [$];
    icache_pkg::warp_id_t    exp_warp [$];

    int unsigned seed = 25;
    int          mem_reqs;
    logic        stall_mode;

    icache_top uut (.*);

    always #2 clk_i = ~clk_i;

    // ########################################
    // Helpers

    function automatic int unsigned lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 16;
    endfunction

    // Memory content, word w of line a
    function automatic icache_pkg::line_t ref_line(icache_pkg::line_addr_t a);
        icache_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*4 +: 4] = 4'((int'(a) * 4 + w) * 5 + 3);
        end
        return l;
    endfunction

    // Expected decoder window for one request
    function automatic void ref_window(input icache_pkg::pc_t pc,
                                       input icache_pkg::fetch_mask_t mask,
                                       output icache_pkg::fetch_mask_t valid,
                                       output icache_pkg::inst_vec_t insts);
        icache_pkg::line_t l;
        int                off;
        l     = ref_line(pc[7:2]);
        off   = int'(pc[1:0]);
        valid = '0;
        insts = '0;
        for (int k = 0; k < 2; k++) begin
            if (mask[k] && (off + k < 4)) begin
                valid[k]       = 1'b1;
                insts[k*4 +: 4] = l[(off+k)*4 +: 4];
            end
        end
    endfunction

    task automatic fail_now(string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_insts(icache_pkg::inst_vec_t got, icache_pkg::inst_vec_t exp,
                               string what);
        if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_mask(icache_pkg::fetch_mask_t got, icache_pkg::fetch_mask_t exp,
                              string what);
        if (got !== exp) fail_now($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic check_pc(icache_pkg::pc_t got, icache_pkg::pc_t exp, string what);
        if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_side(icache_pkg::warp_id_t got_w, icache_pkg::warp_id_t exp_w,
                              icache_pkg::act_mask_t got_a, icache_pkg::act_mask_t exp_a);
        if (got_w !== exp_w || got_a !== exp_a) begin
            fail_now($sformatf("sideband got %0d/%h expected %0d/%h",
                               got_w, got_a, exp_w, exp_a));
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) fail_now($sformatf("%s got %0d expected %0d", what, got, exp));
    endtask

    // ########################################
    // Memory model

    initial begin
        int unsigned lat;
        forever begin
            @(negedge clk_i);
            mem_ready_i = (lcg_next() & 32'd1) != 0;
            #1;
            if (mem_req_o && mem_ready_i) begin
                mem_reqs++;
                if (exp_pc.size() == 0) fail_now("memory request with no open fetch");
                if (mem_addr_o !== exp_pc[0][7:2]) begin
                    fail_now($sformatf("mem_addr_o got %h expected %h",
                                       mem_addr_o, exp_pc[0][7:2]));
                end
                lat = 1 + lcg_next() % 4;
                @(negedge clk_i);
                mem_ready_i = 1'b0;
                repeat (lat - 1) @(negedge clk_i);
                mem_valid_i = 1'b1;
                mem_data_i  = ref_line(mem_addr_o);
                @(negedge clk_i);
                mem_valid_i = 1'b0;
            end
        end
    end

    // Decoder ready, random only in the stall phase
    always @(negedge clk_i) begin
        dec_ready_i = stall_mode ? ((lcg_next() & 32'd2) != 0) : 1'b1;
    end

    // ########################################
    // Compare process

    initial begin
        logic                    holding;
        icache_pkg::fetch_mask_t v, snap_v;
        icache_pkg::inst_vec_t   ins, snap_i;
        holding = 1'b0;
        forever begin
            @(negedge clk_i);
            #1;
            if (ic_valid_o != '0) begin
                if (!holding) begin
                    if (exp_pc.size() == 0) fail_now("delivery with no accepted request");
                    ref_window(exp_pc[0], exp_mask[0], v, ins);
                    check_mask(ic_valid_o, v, "ic_valid_o");
                    check_insts(ic_inst_o, ins, "ic_inst_o");
                    check_pc(ic_pc_o, exp_pc[0], "ic_pc_o");
                    check_mask(ic_fetch_mask_o, exp_mask[0], "ic_fetch_mask_o");
                    check_side(ic_warp_id_o, exp_warp[0], ic_act_mask_o, exp_act[0]);
                    snap_v  = ic_valid_o;
                    snap_i  = ic_inst_o;
                    holding = 1'b1;
                end else begin
                    // Held stable under back-pressure
                    check_mask(ic_valid_o, snap_v, "stalled ic_valid_o");
                    check_insts(ic_inst_o, snap_i, "stalled ic_inst_o");
                    check_pc(ic_pc_o, exp_pc[0], "stalled ic_pc_o");
                    check_mask(ic_fetch_mask_o, exp_mask[0], "stalled ic_fetch_mask_o");
                    check_side(ic_warp_id_o, exp_warp[0], ic_act_mask_o, exp_act[0]);
                end
                // No new request while the decoder holds off
                if (!dec_ready_i && ic_ready_o) begin
                    fail_now("ic_ready_o high while the decoder stalls");
                end
                if (dec_ready_i) begin
                    void'(exp_pc.pop_front());
                    void'(exp_mask.pop_front());
                    void'(exp_act.pop_front());
                    void'(exp_warp.pop_front());
                    holding = 1'b0;
                end
            end else if (holding) begin
                fail_now("ic_valid_o dropped before the decoder took it");
            end
        end
    end

    // ########################################
    // Stimulus

    task automatic fetch(icache_pkg::pc_t pc, icache_pkg::fetch_mask_t mask);
        int cycles;
        @(negedge clk_i);
        fe_valid_i      = 1'b1;
        fe_pc_i         = pc;
        fe_fetch_mask_i = mask;
        fe_act_mask_i   = {16'(lcg_next()), 16'(lcg_next())};
        fe_warp_id_i    = 3'(lcg_next());
        cycles          = 0;
        #1;
        while (!ic_ready_o) begin
            cycles++;
            if (cycles > 200) fail_now("timeout waiting for ic_ready_o");
            @(negedge clk_i);
            #1;
        end
        exp_pc.push_back(pc);
        exp_mask.push_back(mask);
        exp_act.push_back(fe_act_mask_i);
        exp_warp.push_back(fe_warp_id_i);
        @(negedge clk_i);
        fe_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_pc.size() != 0) begin
            cycles++;
            if (cycles > 500) fail_now("timeout waiting for delivery");
            @(negedge clk_i);
        end
    endtask

    initial begin
        clk_i           = 0;
        rst_ni          = 0;
        flush_i         = 0;
        mem_ready_i     = 0;
        mem_valid_i     = 0;
        mem_data_i      = '0;
        fe_valid_i      = 0;
        fe_fetch_mask_i = '0;
        fe_pc_i         = '0;
        fe_act_mask_i   = '0;
        fe_warp_id_i    = '0;
        dec_ready_i     = 1;
        stall_mode      = 0;
        mem_reqs        = 0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1;

        // Cold miss then hits in the same line
        fetch(8'h24, 2'b11);
        wait_drained();
        check_count(mem_reqs, 1, "cold miss");
        fetch(8'h25, 2'b11);
        fetch(8'h26, 2'b11);
        wait_drained();
        check_count(mem_reqs, 1, "same line hits");
        // Line end and masked slot
        fetch(8'h27, 2'b11);
        fetch(8'h24, 2'b01);
        wait_drained();
        check_count(mem_reqs, 1, "window hits");
        // Tag conflict on index 1
        fetch(8'h64, 2'b11);
        wait_drained();
        check_count(mem_reqs, 2, "conflict");
        fetch(8'h24, 2'b11);
        wait_drained();
        check_count(mem_reqs, 3, "evicted");
        // Flush drops cached lines
        fetch(8'h08, 2'b11);
        fetch(8'h09, 2'b01);
        wait_drained();
        check_count(mem_reqs, 4, "before flush");
        @(negedge clk_i);
        flush_i = 1;
        @(negedge clk_i);
        flush_i = 0;
        fetch(8'h08, 2'b11);
        wait_drained();
        check_count(mem_reqs, 5, "after flush");

        // Random stream with decoder stalls
        stall_mode = 1;
        for (int i = 0; i < 40; i++) begin
            fetch(8'(lcg_next()) & 8'h3f, ((lcg_next() & 32'd4) != 0) ? 2'b11 : 2'b01);
        end
        wait_drained();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule : icache_tb

/* list.f */
src/icache_pkg.sv
src/icache_line_if.sv
src/icache_window_if.sv
src/icache_line_store.sv
src/icache_ctrl.sv
src/icache_window_extract.sv
src/icache_top.sv
verif/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_line_if.sv
  - src/icache_window_if.sv
  - src/icache_line_store.sv
  - src/icache_ctrl.sv
  - src/icache_window_extract.sv
  - src/icache_top.sv
  - target: test
    files:
      - verif/icache_tb.sv
